/* design/iir_consts.svh */
`ifndef IIR_CONSTS_SVH
`define IIR_CONSTS_SVH

// ==========================================================================
// Filter structure
// ==========================================================================
`define IIR_SOS_NUM    5                        // Second-order sections for order 10
`define IIR_SEC_W      3                        // Section counter wide enough for IIR_SOS_NUM

// ==========================================================================
// Number formats
// ==========================================================================
`define IIR_DIN_W      16                       // External input sample in Q1.15
`define IIR_SAMP_WH    4                        // Internal sample whole bits
`define IIR_SAMP_FR    23                       // Internal sample fraction bits
`define IIR_SAMP_W     (`IIR_SAMP_WH + `IIR_SAMP_FR)
`define IIR_COEFF_WH   2                        // Coefficient whole bits
`define IIR_COEFF_FR   14                       // Coefficient fraction bits
`define IIR_COEFF_W    (`IIR_COEFF_WH + `IIR_COEFF_FR)
`define IIR_ACC_GB     4                        // Headroom of the section sum before clamp
`define IIR_ACC_W      (`IIR_SAMP_W + `IIR_ACC_GB)
`define IIR_PROD_W     (`IIR_SAMP_W + `IIR_COEFF_W)

// ==========================================================================
// Coefficient port and sample timing
// ==========================================================================
`define IIR_ADDR_W     5
`define IIR_COEFF_NUM  (4 * `IIR_SOS_NUM)      // Writable addresses 0 .. 19
`define IIR_FS_DIV     24                       // Must exceed 3 * IIR_SOS_NUM
`define IIR_FS_CNT_W   5

`endif

/* design/iir_pkg.sv */
`default_nettype none

`include "iir_consts.svh"

package iir_pkg;

  // ==========================================================================
  // Data words
  // ==========================================================================
  typedef logic signed [`IIR_SAMP_W-1:0]  sample_t;   // Q4.23
  typedef logic signed [`IIR_COEFF_W-1:0] coeff_t;    // Q2.14
  typedef logic signed [`IIR_SAMP_FR:0]   dout_t;     // Sign plus 23 fraction bits

  // Local coefficient address inside one section
  typedef enum logic [1:0] {
    C_B1,
    C_B2,
    C_A1,
    C_A2
  } coeff_sel_e;

  // Slot within the three clocks given to a section
  typedef enum logic [1:0] {
    PH_FF,                                  // x products
    PH_FB,                                  // y products and output update
    PH_IDLE
  } sos_phase_e;

  // ==========================================================================
  // Per-section commands
  // ==========================================================================
  typedef struct packed {
    logic       we;
    coeff_sel_e sel;
    coeff_t     data;
  } coeff_wr_t;

  typedef struct packed {
    logic       ce;
    sos_phase_e phase;
  } sos_ctrl_t;

endpackage

`default_nettype wire

/* design/fs_strobe_gen.sv */
`default_nettype none

`include "iir_consts.svh"

module fs_strobe_gen (
  input  logic clk,
  input  logic nrst,
  output logic fs
);

  logic [`IIR_FS_CNT_W-1:0] cnt;              // Clocks left to the next strobe

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      cnt <= `IIR_FS_CNT_W'(`IIR_FS_DIV - 1);
      fs  <= 1'b0;
    end else begin
      if (cnt == '0) begin
        cnt <= `IIR_FS_CNT_W'(`IIR_FS_DIV - 1); // Reload
        fs  <= 1'b1;
      end else begin
        cnt <= cnt - 1'b1;
        fs  <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/iir_sequencer.sv */
`default_nettype none

`include "iir_consts.svh"

module iir_sequencer
  import iir_pkg::*;
(
  input  logic                           clk,
  input  logic                           nrst,
  input  logic                           fs,
  input  logic                           c_we,
  input  logic [`IIR_ADDR_W-1:0]         c_addr,
  input  coeff_t                         c_in,
  output sos_ctrl_t [`IIR_SOS_NUM-1:0]   sos_ctrl,
  output coeff_wr_t [`IIR_SOS_NUM-1:0]   sos_wr
);

  sos_phase_e              phase;
  logic [`IIR_SEC_W-1:0]   sec_cnt;            // IIR_SOS_NUM means parked
  logic [`IIR_ADDR_W-3:0]  wr_sec;
  logic                    wr_ok;

  // ==========================================================================
  // Slot and section counters
  // ==========================================================================
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      phase   <= PH_IDLE;
      sec_cnt <= `IIR_SEC_W'(`IIR_SOS_NUM);
    end else if (!c_we) begin                  // Frozen during coefficient writes
      if (fs) begin
        phase   <= PH_FF;
        sec_cnt <= '0;
      end else if (sec_cnt != `IIR_SEC_W'(`IIR_SOS_NUM)) begin
        case (phase)
          PH_FF: phase <= PH_FB;
          PH_FB: phase <= PH_IDLE;
          default: begin
            sec_cnt <= sec_cnt + 1'b1;
            phase   <= (sec_cnt == `IIR_SEC_W'(`IIR_SOS_NUM - 1)) ? PH_IDLE : PH_FF;
          end
        endcase
      end
    end
  end

  // One enable per active slot
  always_comb begin
    for (int k = 0; k < `IIR_SOS_NUM; k++) begin
      if (!c_we && phase != PH_IDLE && sec_cnt == `IIR_SEC_W'(k)) begin
        sos_ctrl[k].ce    = 1'b1;
        sos_ctrl[k].phase = phase;
      end else begin
        sos_ctrl[k].ce    = 1'b0;
        sos_ctrl[k].phase = PH_IDLE;
      end
    end
  end

  // ==========================================================================
  // Coefficient address decode
  // ==========================================================================
  assign wr_sec = c_addr[`IIR_ADDR_W-1:2];   // Section a/4
  assign wr_ok  = c_we && (c_addr < `IIR_ADDR_W'(`IIR_COEFF_NUM));

  always_comb begin
    for (int k = 0; k < `IIR_SOS_NUM; k++) begin
      sos_wr[k].we   = wr_ok && (wr_sec == (`IIR_ADDR_W-2)'(k));
      sos_wr[k].sel  = coeff_sel_e'(c_addr[1:0]);
      sos_wr[k].data = c_in;
    end
  end

endmodule

`default_nettype wire

/* design/iir_sos.sv */
`default_nettype none

`include "iir_consts.svh"

module iir_sos
  import iir_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  sos_ctrl_t ctrl,
  input  coeff_wr_t wr,
  input  sample_t   din,
  output sample_t   dout
);

  coeff_t                         b1, b2, a1, a2;
  sample_t                        x0, x1, x2;  // x0 holds the current input
  sample_t                        y1, y2;
  sample_t                        mul_s0, mul_s1;
  coeff_t                         mul_c0, mul_c1;
  logic signed [`IIR_PROD_W-1:0]  prod0, prod1;
  logic signed [`IIR_ACC_W-1:0]   prod_sum;
  logic signed [`IIR_ACC_W-1:0]   acc;
  logic signed [`IIR_ACC_W-1:0]   fb_sum;
  sample_t                        fb_sat;

  // ==========================================================================
  // Coefficient registers
  // ==========================================================================
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      b1 <= '0;
      b2 <= '0;
      a1 <= '0;
      a2 <= '0;
    end else if (wr.we) begin
      case (wr.sel)
        C_B1: b1 <= wr.data;
        C_B2: b2 <= wr.data;
        C_A1: a1 <= wr.data;
        default: a2 <= wr.data;
      endcase
    end
  end

  // ==========================================================================
  // Shared multiplier pair
  // ==========================================================================
  always_comb begin
    if (ctrl.phase == PH_FF) begin
      mul_s0 = x1;
      mul_c0 = b1;
      mul_s1 = x2;
      mul_c1 = b2;
    end else begin
      mul_s0 = y1;
      mul_c0 = a1;
      mul_s1 = y2;
      mul_c1 = a2;
    end
  end

  assign prod0    = mul_s0 * mul_c0;
  assign prod1    = mul_s1 * mul_c1;
  assign prod_sum = `IIR_ACC_W'(prod0 >>> `IIR_COEFF_FR)
                  + `IIR_ACC_W'(prod1 >>> `IIR_COEFF_FR);  // Floored products

  assign fb_sum = acc - prod_sum;

  // Clamp the section sum into the sample range
  always_comb begin
    if (&fb_sum[`IIR_ACC_W-1:`IIR_SAMP_W-1] || ~|fb_sum[`IIR_ACC_W-1:`IIR_SAMP_W-1]) begin
      fb_sat = fb_sum[`IIR_SAMP_W-1:0];
    end else if (fb_sum[`IIR_ACC_W-1]) begin
      fb_sat = {1'b1, {(`IIR_SAMP_W-1){1'b0}}};
    end else begin
      fb_sat = {1'b0, {(`IIR_SAMP_W-1){1'b1}}};
    end
  end

  // Feed-forward sum and captured input
  always_ff @(posedge clk) begin
    if (ctrl.ce && ctrl.phase == PH_FF) begin
      acc <= `IIR_ACC_W'(din) + prod_sum;
      x0  <= din;
    end
  end

  // Delay line steps once per sample at the end of PH_FB
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      x1 <= '0;
      x2 <= '0;
      y1 <= '0;
      y2 <= '0;
    end else if (ctrl.ce && ctrl.phase == PH_FB) begin
      x1 <= x0;
      x2 <= x1;
      y1 <= fb_sat;
      y2 <= y1;
    end
  end

  assign dout = y1;

endmodule

`default_nettype wire

/* design/iir_filter.sv */
`default_nettype none

`include "iir_consts.svh"

module iir_filter
  import iir_pkg::*;
(
  input  logic                         clk,
  input  logic                         nrst,
  input  logic                         c_we,
  input  logic [`IIR_ADDR_W-1:0]       c_addr,
  input  coeff_t                       c_in,
  input  logic signed [`IIR_DIN_W-1:0] din,
  output dout_t                        dout,
  output logic                         fs
);

  sos_ctrl_t [`IIR_SOS_NUM-1:0]  sos_ctrl;
  coeff_wr_t [`IIR_SOS_NUM-1:0]  sos_wr;
  sample_t                       samp [0:`IIR_SOS_NUM];
  sample_t                       last;

  fs_strobe_gen u_fs_gen (
    .clk  (clk),
    .nrst (nrst),
    .fs   (fs)
  );

  iir_sequencer u_seq (
    .clk      (clk),
    .nrst     (nrst),
    .fs       (fs),
    .c_we     (c_we),
    .c_addr   (c_addr),
    .c_in     (c_in),
    .sos_ctrl (sos_ctrl),
    .sos_wr   (sos_wr)
  );

  // ==========================================================================
  // Section chain
  // ==========================================================================
  assign samp[0] = sample_t'(din) <<< (`IIR_SAMP_FR - (`IIR_DIN_W - 1));  // Q1.15 to Q4.23

  for (genvar i = 0; i < `IIR_SOS_NUM; i++) begin : g_sos
    iir_sos u_sos (
      .clk  (clk),
      .nrst (nrst),
      .ctrl (sos_ctrl[i]),
      .wr   (sos_wr[i]),
      .din  (samp[i]),
      .dout (samp[i+1])
    );
  end

  assign last = samp[`IIR_SOS_NUM];

  // Clamp to full scale unless the whole bits are a sign extension
  always_comb begin
    if (&last[`IIR_SAMP_W-1:`IIR_SAMP_FR] || ~|last[`IIR_SAMP_W-1:`IIR_SAMP_FR]) begin
      dout = last[`IIR_SAMP_FR:0];
    end else if (last[`IIR_SAMP_W-1]) begin
      dout = {1'b1, {`IIR_SAMP_FR{1'b0}}};
    end else begin
      dout = {1'b0, {`IIR_SAMP_FR{1'b1}}};
    end
  end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic nrst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                    // Period 10
  end

  initial begin
    nrst = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    nrst = 1'b1;                              // Released just after the third edge
  end

endmodule

`default_nettype wire

/* verification/tb_iir_filter.sv */
`default_nettype none

`include "iir_consts.svh"

module tb_iir_filter
  import iir_pkg::*;
();

  typedef struct packed {
    logic [1:0]         cset;                 // Coefficient set index
    logic signed [15:0] din;
    dout_t              exp;
  } row_t;

  logic                   clk;
  logic                   nrst;
  logic                   c_we;
  logic [`IIR_ADDR_W-1:0] c_addr;
  coeff_t                 c_in;
  logic signed [15:0]     din;
  dout_t                  dout;
  logic                   fs;

  logic [15:0]            lfsr;
  coeff_t                 coeff_tbl [0:3][0:31];
  row_t                   rows [$];
  int                     cur_set;

  tb_clock_gen u_clk_gen (
    .clk  (clk),
    .nrst (nrst)
  );

  iir_filter i_dut (
    .clk    (clk),
    .nrst   (nrst),
    .c_we   (c_we),
    .c_addr (c_addr),
    .c_in   (c_in),
    .din    (din),
    .dout   (dout),
    .fs     (fs)
  );

  // ==========================================================================
  // Checks
  // ==========================================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_dout(input dout_t got, input dout_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: dout got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_fs(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: fs got %b expected %b", $time, got, exp));
    end
  endtask

  // ==========================================================================
  // Stimulus helpers
  // ==========================================================================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11
  endfunction

  task automatic rand_din(output logic signed [15:0] v);
    for (int b = 0; b < 16; b++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  task automatic wait_fs();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!fs && n < 2 * `IIR_FS_DIV);
    if (!fs) abort_run("No sample strobe within two sample periods");
  endtask

  task automatic load_coeffs(input int cs);
    c_we = 1'b1;
    for (int a = 0; a < 32; a++) begin      // 20 .. 31 must be ignored
      c_addr = `IIR_ADDR_W'(a);
      c_in   = coeff_tbl[cs][a];
      @(posedge clk);
      #1;
    end
    c_we   = 1'b0;
    c_addr = '0;
    c_in   = '0;
  endtask

  task automatic fill_coeffs();
    for (int s = 0; s < 4; s++) begin
      for (int a = 0; a < 32; a++) begin
        coeff_tbl[s][a] = (a < `IIR_COEFF_NUM) ? '0 : coeff_t'(16'h3000 + a);
      end
    end
    coeff_tbl[1][2]  = 16'hE000;              // Section 0 a1 = -0.5
    coeff_tbl[2][8]  = 16'h4000;              // Section 2 b1 = 1
    coeff_tbl[2][17] = 16'h2000;              // Section 4 b2 = 0.5
    for (int k = 0; k < `IIR_SOS_NUM; k++) begin
      coeff_tbl[3][4*k+2] = 16'hE000;
    end
  endtask

  task automatic add_flush();
    for (int k = 0; k < 2; k++) begin
      rows.push_back(row_t'{2'd0, 16'sd0, 24'h000000});  // Clears all delays
    end
  endtask

  task automatic build_rows();
    logic signed [15:0] d;
    dout_t              ff_exp [0:4] = '{24'h100000, 24'h100000, 24'h080000,
                                         24'h080000, 24'h000000};
    for (int k = 0; k < 6; k++) begin
      rand_din(d);
      rows.push_back(row_t'{2'd0, d, dout_t'({d, 8'h00})});
    end
    add_flush();
    for (int k = 0; k < 6; k++) begin         // Impulse 4096 scales to 2^20 and halves each sample
      d = (k == 0) ? 16'sd4096 : 16'sd0;
      rows.push_back(row_t'{2'd1, d, dout_t'(24'h100000 >> k)});
    end
    add_flush();
    for (int k = 0; k < 5; k++) begin
      d = (k == 0) ? 16'sd4096 : 16'sd0;
      rows.push_back(row_t'{2'd2, d, ff_exp[k]});
    end
    add_flush();
    d = 16'sd16000;
    for (int k = 0; k < 4; k++) begin
      rows.push_back(row_t'{2'd3, d, (k == 0) ? dout_t'({d, 8'h00}) : 24'h7FFFFF});
    end
    add_flush();
    d = -16'sd16000;
    for (int k = 0; k < 4; k++) begin
      rows.push_back(row_t'{2'd3, d, (k == 0) ? dout_t'({d, 8'h00}) : 24'h800000});
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    int n;
    c_we    = 1'b0;
    c_addr  = '0;
    c_in    = '0;
    din     = '0;
    lfsr    = 16'd17;
    cur_set = -1;
    fill_coeffs();
    build_rows();

    n = 0;
    while (nrst !== 1'b1 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (nrst !== 1'b1) abort_run("Reset was never released");

    // First strobe and then two full periods
    for (int p = 0; p < 3; p++) begin
      for (int k = 1; k <= `IIR_FS_DIV; k++) begin
        @(posedge clk);
        #1;
        check_fs(fs, k == `IIR_FS_DIV);
        check_dout(dout, '0);
      end
    end

    foreach (rows[i]) begin
      if (int'(rows[i].cset) != cur_set) begin
        load_coeffs(int'(rows[i].cset));
        cur_set = int'(rows[i].cset);
      end
      wait_fs();
      din = rows[i].din;                      // Taken in the clock after fs
      repeat (3 * `IIR_SOS_NUM + 2) @(posedge clk);
      #1;
      check_dout(dout, rows[i].exp);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/iir_pkg.sv
design/fs_strobe_gen.sv
design/iir_sequencer.sv
design/iir_sos.sv
design/iir_filter.sv
verification/tb_clock_gen.sv
verification/tb_iir_filter.sv

/* Makefile */
OBJ = obj_dir

all: run

build:
	verilator --binary --timing -j 0 -f sim.f --top-module tb_iir_filter --Mdir $(OBJ)

run: build
	./$(OBJ)/Vtb_iir_filter > sim.log 2>&1 ; cat sim.log
	grep -q "^Verification passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tb_iir_filter

clean:
	rm -rf $(OBJ) sim.log

.PHONY: all build run lint clean
